// File: hw/ooo_pkg.sv
package ooo_pkg;

    localparam int PREG_W = 6;
    localparam int NUM_PREGS = 1 << PREG_W;
    localparam int XLEN = 32;
    // sources per micro-op
    localparam int NUM_SRCS = 2;

    typedef logic [PREG_W-1:0] preg_idx_t;
    typedef logic [XLEN-1:0] xlen_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_XOR,
        ALU_ADDI,
        ALU_LI
    } alu_op_e;

    // renamed micro-op as it enters the queue
    typedef struct packed {
        alu_op_e op;
        preg_idx_t [NUM_SRCS-1:0] src;
        preg_idx_t dst;
        xlen_t imm;
    } uop_t;

    // result broadcast, one per lane
    typedef struct packed {
        logic vld;
        preg_idx_t dst;
        xlen_t data;
    } wb_t;

    // tag only, no data
    typedef struct packed {
        logic vld;
        preg_idx_t dst;
    } wakeup_t;

    typedef enum logic {
        IDLE,
        WAIT_DROP
    } disp_state_e;

endpackage

// File: hw/dispatch_rx.sv
module dispatch_rx (
    input  logic clk,
    input  logic rst,
    input  logic i_disp_req,
    input  ooo_pkg::uop_t i_disp_uop,
    output logic o_disp_ack,
    input  logic i_can_enq,
    input  logic [ooo_pkg::NUM_SRCS-1:0] i_src_rdy,
    output logic o_enq_vld,
    output ooo_pkg::uop_t o_enq_uop,
    output logic [ooo_pkg::NUM_SRCS-1:0] o_enq_src_rdy,
    output logic o_alloc_vld,
    output ooo_pkg::preg_idx_t o_alloc_dst
);

    ooo_pkg::disp_state_e state_q;
    ooo_pkg::disp_state_e state_d;
    logic fire;

    // accept only from idle and only with room in the queue
    assign fire = (state_q == ooo_pkg::IDLE) && i_disp_req && i_can_enq;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ooo_pkg::IDLE: begin
                if (fire) begin
                    state_d = ooo_pkg::WAIT_DROP;
                end
            end
            ooo_pkg::WAIT_DROP: begin
                // hold ack until the driver lets go of req
                if (!i_disp_req) begin
                    state_d = ooo_pkg::IDLE;
                end
            end
            default: state_d = ooo_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ooo_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // ack comes straight from the state register
    assign o_disp_ack = (state_q == ooo_pkg::WAIT_DROP);

    // one-cycle enqueue and allocate pulse
    assign o_enq_vld = fire;
    assign o_enq_uop = i_disp_uop;
    assign o_enq_src_rdy = i_src_rdy;
    assign o_alloc_vld = fire;
    assign o_alloc_dst = i_disp_uop.dst;

endmodule

// File: hw/ready_scoreboard.sv
module ready_scoreboard #(
    parameter int ISSUE_WIDTH = 2
) (
    input  logic clk,
    input  logic rst,
    input  logic i_alloc_vld,
    input  ooo_pkg::preg_idx_t i_alloc_dst,
    input  ooo_pkg::wb_t [ISSUE_WIDTH-1:0] i_wb,
    input  ooo_pkg::preg_idx_t [ooo_pkg::NUM_SRCS-1:0] i_query_src,
    output logic [ooo_pkg::NUM_SRCS-1:0] o_src_rdy
);

    logic [ooo_pkg::NUM_PREGS-1:0] rdy_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            rdy_q <= '1;
        end else begin
            if (i_alloc_vld) begin
                rdy_q[i_alloc_dst] <= 1'b0;
            end
            // later assignment, so writeback beats allocation
            for (int l = 0; l < ISSUE_WIDTH; l++) begin
                if (i_wb[l].vld) begin
                    rdy_q[i_wb[l].dst] <= 1'b1;
                end
            end
        end
    end

    // same-cycle writeback counts as ready
    always_comb begin
        for (int s = 0; s < ooo_pkg::NUM_SRCS; s++) begin
            o_src_rdy[s] = rdy_q[i_query_src[s]];
            for (int l = 0; l < ISSUE_WIDTH; l++) begin
                if (i_wb[l].vld && (i_wb[l].dst == i_query_src[s])) begin
                    o_src_rdy[s] = 1'b1;
                end
            end
        end
    end

endmodule

// File: hw/issue_queue.sv
module issue_queue #(
    parameter int IQ_DEPTH = 8,
    parameter int ISSUE_WIDTH = 2
) (
    input  logic clk,
    input  logic rst,
    input  logic i_enq_vld,
    input  ooo_pkg::uop_t i_enq_uop,
    input  logic [ooo_pkg::NUM_SRCS-1:0] i_enq_src_rdy,
    output logic o_can_enq,
    output logic [ISSUE_WIDTH-1:0] o_iss_vld,
    output logic [ISSUE_WIDTH-1:0][$clog2(IQ_DEPTH)-1:0] o_iss_idx,
    output ooo_pkg::uop_t [ISSUE_WIDTH-1:0] o_iss_uop,
    input  logic [ISSUE_WIDTH-1:0] i_fin_vld,
    input  logic [ISSUE_WIDTH-1:0][$clog2(IQ_DEPTH)-1:0] i_fin_idx,
    input  ooo_pkg::wb_t [ISSUE_WIDTH-1:0] i_wb
);

    localparam int IDX_W = $clog2(IQ_DEPTH);

    typedef struct packed {
        logic vld;
        logic issued;
        logic [ooo_pkg::NUM_SRCS-1:0] rdy;
        logic [ooo_pkg::NUM_SRCS-1:0] spec;
        ooo_pkg::uop_t uop;
    } iq_entry_t;

    iq_entry_t entry_q [IQ_DEPTH];
    iq_entry_t enq_entry;
    logic [IQ_DEPTH-1:0] entry_rdy;
    logic [ISSUE_WIDTH-1:0] sel_vld;
    logic [ISSUE_WIDTH-1:0][IDX_W-1:0] sel_idx;
    logic [IDX_W-1:0] free_idx;
    logic has_free;
    ooo_pkg::wakeup_t [ISSUE_WIDTH-1:0] wb_tag;
    ooo_pkg::wakeup_t [ISSUE_WIDTH-1:0] int_wakeup;

    function automatic logic tag_hit(
        input ooo_pkg::wakeup_t [ISSUE_WIDTH-1:0] bus,
        input ooo_pkg::preg_idx_t tag
    );
        logic hit;
        hit = 1'b0;
        for (int l = 0; l < ISSUE_WIDTH; l++) begin
            hit |= bus[l].vld && (bus[l].dst == tag);
        end
        return hit;
    endfunction

    // tag view of the writeback bus
    always_comb begin
        for (int l = 0; l < ISSUE_WIDTH; l++) begin
            wb_tag[l].vld = i_wb[l].vld;
            wb_tag[l].dst = i_wb[l].dst;
        end
    end

    // true ready or speculatively ready, never both half-way
    always_comb begin
        for (int e = 0; e < IQ_DEPTH; e++) begin
            entry_rdy[e] = entry_q[e].vld && !entry_q[e].issued &&
                           ((&entry_q[e].rdy) || (&entry_q[e].spec));
        end
    end

    // oldest-index-first select, lane 0 picks first
    always_comb begin
        logic [IQ_DEPTH-1:0] taken;
        taken = '0;
        for (int l = 0; l < ISSUE_WIDTH; l++) begin
            sel_vld[l] = 1'b0;
            sel_idx[l] = '0;
            for (int e = IQ_DEPTH - 1; e >= 0; e--) begin
                if (entry_rdy[e] && !taken[e]) begin
                    sel_vld[l] = 1'b1;
                    sel_idx[l] = IDX_W'(e);
                end
            end
            if (sel_vld[l]) begin
                taken[sel_idx[l]] = 1'b1;
            end
            // single-cycle ALUs, so this wakeup is always right
            int_wakeup[l].vld = sel_vld[l];
            int_wakeup[l].dst = entry_q[sel_idx[l]].uop.dst;
        end
    end

    // lowest free slot
    always_comb begin
        has_free = 1'b0;
        free_idx = '0;
        for (int e = IQ_DEPTH - 1; e >= 0; e--) begin
            if (!entry_q[e].vld) begin
                has_free = 1'b1;
                free_idx = IDX_W'(e);
            end
        end
    end

    assign o_can_enq = has_free;

    // incoming entry also sees this cycle's wakeups
    always_comb begin
        enq_entry.vld = 1'b1;
        enq_entry.issued = 1'b0;
        enq_entry.uop = i_enq_uop;
        for (int s = 0; s < ooo_pkg::NUM_SRCS; s++) begin
            enq_entry.rdy[s] = i_enq_src_rdy[s] || tag_hit(wb_tag, i_enq_uop.src[s]);
            enq_entry.spec[s] = enq_entry.rdy[s] || tag_hit(int_wakeup, i_enq_uop.src[s]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_iss_vld <= '0;
            for (int e = 0; e < IQ_DEPTH; e++) begin
                entry_q[e].vld <= 1'b0;
                entry_q[e].issued <= 1'b0;
            end
        end else begin
            o_iss_vld <= sel_vld;
            for (int e = 0; e < IQ_DEPTH; e++) begin
                for (int s = 0; s < ooo_pkg::NUM_SRCS; s++) begin
                    if (tag_hit(wb_tag, entry_q[e].uop.src[s])) begin
                        entry_q[e].rdy[s] <= 1'b1;
                        entry_q[e].spec[s] <= 1'b1;
                    end else if (tag_hit(int_wakeup, entry_q[e].uop.src[s])) begin
                        entry_q[e].spec[s] <= 1'b1;
                    end
                end
            end
            for (int l = 0; l < ISSUE_WIDTH; l++) begin
                if (sel_vld[l]) begin
                    entry_q[sel_idx[l]].issued <= 1'b1;
                end
                // operands read, slot can go
                if (i_fin_vld[l]) begin
                    entry_q[i_fin_idx[l]].vld <= 1'b0;
                end
            end
            if (i_enq_vld && has_free) begin
                entry_q[free_idx] <= enq_entry;
            end
        end
        o_iss_idx <= sel_idx;
        for (int l = 0; l < ISSUE_WIDTH; l++) begin
            o_iss_uop[l] <= entry_q[sel_idx[l]].uop;
        end
    end

endmodule

// File: hw/operand_read.sv
module operand_read #(
    parameter int IQ_DEPTH = 8,
    parameter int ISSUE_WIDTH = 2
) (
    input  logic clk,
    input  logic rst,
    input  logic [ISSUE_WIDTH-1:0] i_iss_vld,
    input  logic [ISSUE_WIDTH-1:0][$clog2(IQ_DEPTH)-1:0] i_iss_idx,
    input  ooo_pkg::uop_t [ISSUE_WIDTH-1:0] i_iss_uop,
    output logic [ISSUE_WIDTH-1:0] o_fin_vld,
    output logic [ISSUE_WIDTH-1:0][$clog2(IQ_DEPTH)-1:0] o_fin_idx,
    input  ooo_pkg::wb_t [ISSUE_WIDTH-1:0] i_alu_fwd,
    input  ooo_pkg::wb_t [ISSUE_WIDTH-1:0] i_wb,
    output logic [ISSUE_WIDTH-1:0] o_ex_vld,
    output ooo_pkg::uop_t [ISSUE_WIDTH-1:0] o_ex_uop,
    output ooo_pkg::xlen_t [ISSUE_WIDTH-1:0] o_ex_opa,
    output ooo_pkg::xlen_t [ISSUE_WIDTH-1:0] o_ex_opb
);

    ooo_pkg::xlen_t regs [ooo_pkg::NUM_PREGS];

    // newest value wins: ALU stage, then writeback, then the array
    function automatic ooo_pkg::xlen_t pick_src(input ooo_pkg::preg_idx_t tag);
        ooo_pkg::xlen_t val;
        val = regs[tag];
        for (int l = 0; l < ISSUE_WIDTH; l++) begin
            if (i_wb[l].vld && (i_wb[l].dst == tag)) begin
                val = i_wb[l].data;
            end
        end
        for (int l = 0; l < ISSUE_WIDTH; l++) begin
            if (i_alu_fwd[l].vld && (i_alu_fwd[l].dst == tag)) begin
                val = i_alu_fwd[l].data;
            end
        end
        return val;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < ooo_pkg::NUM_PREGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int l = 0; l < ISSUE_WIDTH; l++) begin
                if (i_wb[l].vld) begin
                    regs[i_wb[l].dst] <= i_wb[l].data;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_ex_vld <= '0;
        end else begin
            o_ex_vld <= i_iss_vld;
        end
        for (int l = 0; l < ISSUE_WIDTH; l++) begin
            o_ex_uop[l] <= i_iss_uop[l];
            o_ex_opa[l] <= pick_src(i_iss_uop[l].src[0]);
            o_ex_opb[l] <= pick_src(i_iss_uop[l].src[1]);
        end
    end

    // read never fails, so every issue finishes here
    assign o_fin_vld = i_iss_vld;
    assign o_fin_idx = i_iss_idx;

endmodule

// File: hw/alu_pipe.sv
module alu_pipe #(
    parameter int ISSUE_WIDTH = 2
) (
    input  logic clk,
    input  logic rst,
    input  logic [ISSUE_WIDTH-1:0] i_ex_vld,
    input  ooo_pkg::uop_t [ISSUE_WIDTH-1:0] i_ex_uop,
    input  ooo_pkg::xlen_t [ISSUE_WIDTH-1:0] i_ex_opa,
    input  ooo_pkg::xlen_t [ISSUE_WIDTH-1:0] i_ex_opb,
    output ooo_pkg::wb_t [ISSUE_WIDTH-1:0] o_alu_fwd,
    output ooo_pkg::wb_t [ISSUE_WIDTH-1:0] o_wb
);

    function automatic ooo_pkg::xlen_t alu_eval(
        input ooo_pkg::uop_t uop,
        input ooo_pkg::xlen_t a,
        input ooo_pkg::xlen_t b
    );
        ooo_pkg::xlen_t res;
        case (uop.op)
            ooo_pkg::ALU_ADD:  res = a + b;
            ooo_pkg::ALU_SUB:  res = a - b;
            ooo_pkg::ALU_XOR:  res = a ^ b;
            ooo_pkg::ALU_ADDI: res = a + uop.imm;
            ooo_pkg::ALU_LI:   res = uop.imm;
            default:           res = '0;
        endcase
        return res;
    endfunction

    // ALU stage result, also the forward path
    always_comb begin
        for (int l = 0; l < ISSUE_WIDTH; l++) begin
            o_alu_fwd[l].vld = i_ex_vld[l];
            o_alu_fwd[l].dst = i_ex_uop[l].dst;
            o_alu_fwd[l].data = alu_eval(i_ex_uop[l], i_ex_opa[l], i_ex_opb[l]);
        end
    end

    always_ff @(posedge clk) begin
        for (int l = 0; l < ISSUE_WIDTH; l++) begin
            if (rst) begin
                o_wb[l].vld <= 1'b0;
            end else begin
                o_wb[l].vld <= o_alu_fwd[l].vld;
            end
            o_wb[l].dst <= o_alu_fwd[l].dst;
            o_wb[l].data <= o_alu_fwd[l].data;
        end
    end

endmodule

// File: hw/ooo_issue_top.sv
module ooo_issue_top #(
    parameter int IQ_DEPTH = 8,
    parameter int ISSUE_WIDTH = 2
) (
    input  logic clk,
    input  logic rst,
    input  logic i_disp_req,
    input  ooo_pkg::uop_t i_disp_uop,
    output logic o_disp_ack,
    output ooo_pkg::wb_t [ISSUE_WIDTH-1:0] o_wb
);

    localparam int IDX_W = $clog2(IQ_DEPTH);

    logic can_enq;
    logic [ooo_pkg::NUM_SRCS-1:0] src_rdy;
    logic enq_vld;
    ooo_pkg::uop_t enq_uop;
    logic [ooo_pkg::NUM_SRCS-1:0] enq_src_rdy;
    logic alloc_vld;
    ooo_pkg::preg_idx_t alloc_dst;
    logic [ISSUE_WIDTH-1:0] iss_vld;
    logic [ISSUE_WIDTH-1:0][IDX_W-1:0] iss_idx;
    ooo_pkg::uop_t [ISSUE_WIDTH-1:0] iss_uop;
    logic [ISSUE_WIDTH-1:0] fin_vld;
    logic [ISSUE_WIDTH-1:0][IDX_W-1:0] fin_idx;
    logic [ISSUE_WIDTH-1:0] ex_vld;
    ooo_pkg::uop_t [ISSUE_WIDTH-1:0] ex_uop;
    ooo_pkg::xlen_t [ISSUE_WIDTH-1:0] ex_opa;
    ooo_pkg::xlen_t [ISSUE_WIDTH-1:0] ex_opb;
    ooo_pkg::wb_t [ISSUE_WIDTH-1:0] alu_fwd;
    ooo_pkg::wb_t [ISSUE_WIDTH-1:0] wb;

    assign o_wb = wb;

    dispatch_rx dispatch_rx_inst (
        .clk(clk),
        .rst(rst),
        .i_disp_req(i_disp_req),
        .i_disp_uop(i_disp_uop),
        .o_disp_ack(o_disp_ack),
        .i_can_enq(can_enq),
        .i_src_rdy(src_rdy),
        .o_enq_vld(enq_vld),
        .o_enq_uop(enq_uop),
        .o_enq_src_rdy(enq_src_rdy),
        .o_alloc_vld(alloc_vld),
        .o_alloc_dst(alloc_dst)
    );

    // queried with the sources of the micro-op on the dispatch port
    ready_scoreboard #(.ISSUE_WIDTH(ISSUE_WIDTH)) ready_scoreboard_inst (
        .clk(clk),
        .rst(rst),
        .i_alloc_vld(alloc_vld),
        .i_alloc_dst(alloc_dst),
        .i_wb(wb),
        .i_query_src(i_disp_uop.src),
        .o_src_rdy(src_rdy)
    );

    issue_queue #(.IQ_DEPTH(IQ_DEPTH), .ISSUE_WIDTH(ISSUE_WIDTH)) issue_queue_inst (
        .clk(clk),
        .rst(rst),
        .i_enq_vld(enq_vld),
        .i_enq_uop(enq_uop),
        .i_enq_src_rdy(enq_src_rdy),
        .o_can_enq(can_enq),
        .o_iss_vld(iss_vld),
        .o_iss_idx(iss_idx),
        .o_iss_uop(iss_uop),
        .i_fin_vld(fin_vld),
        .i_fin_idx(fin_idx),
        .i_wb(wb)
    );

    operand_read #(.IQ_DEPTH(IQ_DEPTH), .ISSUE_WIDTH(ISSUE_WIDTH)) operand_read_inst (
        .clk(clk),
        .rst(rst),
        .i_iss_vld(iss_vld),
        .i_iss_idx(iss_idx),
        .i_iss_uop(iss_uop),
        .o_fin_vld(fin_vld),
        .o_fin_idx(fin_idx),
        .i_alu_fwd(alu_fwd),
        .i_wb(wb),
        .o_ex_vld(ex_vld),
        .o_ex_uop(ex_uop),
        .o_ex_opa(ex_opa),
        .o_ex_opb(ex_opb)
    );

    alu_pipe #(.ISSUE_WIDTH(ISSUE_WIDTH)) alu_pipe_inst (
        .clk(clk),
        .rst(rst),
        .i_ex_vld(ex_vld),
        .i_ex_uop(ex_uop),
        .i_ex_opa(ex_opa),
        .i_ex_opb(ex_opb),
        .o_alu_fwd(alu_fwd),
        .o_wb(wb)
    );

endmodule

// File: bench/ooo_issue_checker.sv
module ooo_issue_checker #(
    parameter int ISSUE_WIDTH = 2
) (
    input logic clk,
    input logic rst,
    input logic i_disp_req,
    input ooo_pkg::uop_t i_disp_uop,
    input logic i_disp_ack,
    input ooo_pkg::wb_t [ISSUE_WIDTH-1:0] i_wb
);
    timeunit 1ns;
    timeprecision 1ps;

    ooo_pkg::uop_t rec [ooo_pkg::NUM_PREGS];
    ooo_pkg::xlen_t shadow [ooo_pkg::NUM_PREGS];
    logic [ooo_pkg::NUM_SRCS-1:0] dep_on [ooo_pkg::NUM_PREGS];
    logic [ooo_pkg::NUM_PREGS-1:0] pending;
    ooo_pkg::xlen_t [ISSUE_WIDTH-1:0] exp_data;
    logic [ISSUE_WIDTH-1:0] early;
    logic dup_dst;
    logic wb_any;
    int fail_cnt = 0;

    function automatic ooo_pkg::xlen_t apply_op(
        input ooo_pkg::uop_t u,
        input ooo_pkg::xlen_t a,
        input ooo_pkg::xlen_t b
    );
        case (u.op)
            ooo_pkg::ALU_ADD:  return a + b;
            ooo_pkg::ALU_SUB:  return a - b;
            ooo_pkg::ALU_XOR:  return a ^ b;
            ooo_pkg::ALU_ADDI: return a + u.imm;
            default:           return u.imm;
        endcase
    endfunction

    // LI reads nothing, ADDI only its first source
    function automatic logic uses_src(input ooo_pkg::alu_op_e op, input int k);
        if (op == ooo_pkg::ALU_LI) begin
            return 1'b0;
        end
        return (op != ooo_pkg::ALU_ADDI) || (k == 0);
    endfunction

    always_comb begin
        ooo_pkg::uop_t u;
        wb_any = 1'b0;
        dup_dst = 1'b0;
        for (int l = 0; l < ISSUE_WIDTH; l++) begin
            u = rec[i_wb[l].dst];
            exp_data[l] = apply_op(u, shadow[u.src[0]], shadow[u.src[1]]);
            early[l] = 1'b0;
            for (int s = 0; s < ooo_pkg::NUM_SRCS; s++) begin
                early[l] |= uses_src(u.op, s) && dep_on[i_wb[l].dst][s] && pending[u.src[s]];
            end
            wb_any |= i_wb[l].vld;
            for (int m = l + 1; m < ISSUE_WIDTH; m++) begin
                dup_dst |= i_wb[l].vld && i_wb[m].vld && (i_wb[l].dst == i_wb[m].dst);
            end
        end
    end

    // shadow register values and in-flight destinations
    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= '0;
            for (int r = 0; r < ooo_pkg::NUM_PREGS; r++) begin
                shadow[r] <= '0;
            end
        end else begin
            for (int l = 0; l < ISSUE_WIDTH; l++) begin
                if (i_wb[l].vld) begin
                    shadow[i_wb[l].dst] <= i_wb[l].data;
                    pending[i_wb[l].dst] <= 1'b0;
                end
            end
            if (i_disp_req && !i_disp_ack) begin
                rec[i_disp_uop.dst] <= i_disp_uop;
                pending[i_disp_uop.dst] <= 1'b1;
                for (int s = 0; s < ooo_pkg::NUM_SRCS; s++) begin
                    dep_on[i_disp_uop.dst][s] <= pending[i_disp_uop.src[s]];
                end
            end
        end
    end

    for (genvar l = 0; l < ISSUE_WIDTH; l++) begin : g_lane
        a_wb_data: assert property (@(posedge clk) disable iff (rst)
            i_wb[l].vld |-> (i_wb[l].data == exp_data[l]))
        else begin
            $error("mismatch o_wb[%0d].data got %h expected %h", l,
                   $sampled(i_wb[l].data), $sampled(exp_data[l]));
            fail_cnt++;
        end

        a_wb_order: assert property (@(posedge clk) disable iff (rst)
            i_wb[l].vld |-> !early[l])
        else begin
            $error("result for p%0d came back before one of its sources", $sampled(i_wb[l].dst));
            fail_cnt++;
        end

        a_wb_once: assert property (@(posedge clk) disable iff (rst)
            i_wb[l].vld |-> pending[i_wb[l].dst])
        else begin
            $error("writeback for p%0d with no dispatch waiting on it", $sampled(i_wb[l].dst));
            fail_cnt++;
        end
    end

    a_wb_dup: assert property (@(posedge clk) disable iff (rst) !dup_dst)
    else begin
        $error("two lanes wrote back the same destination in one cycle");
        fail_cnt++;
    end

    a_ack_rise: assert property (@(posedge clk) disable iff (rst)
        $rose(i_disp_ack) |-> $past(i_disp_req))
    else begin
        $error("dispatch ack rose while req was low");
        fail_cnt++;
    end

    a_ack_fall: assert property (@(posedge clk) disable iff (rst)
        $fell(i_disp_ack) |-> !$past(i_disp_req))
    else begin
        $error("dispatch ack fell while req was still high");
        fail_cnt++;
    end

    a_reset_state: assert property (@(posedge clk) $fell(rst) |-> (!i_disp_ack && !wb_any))
    else begin
        $error("ack or writeback valid not low right after reset");
        fail_cnt++;
    end

endmodule

bind ooo_issue_top ooo_issue_checker #(.ISSUE_WIDTH(ISSUE_WIDTH)) ooo_issue_checker_inst (
    .clk(clk),
    .rst(rst),
    .i_disp_req(i_disp_req),
    .i_disp_uop(i_disp_uop),
    .i_disp_ack(o_disp_ack),
    .i_wb(o_wb)
);

// File: bench/ooo_issue_tb.sv
module ooo_issue_tb;
    timeunit 1ns;
    timeprecision 1ps;

    logic clk;
    logic rst;
    logic i_disp_req;
    ooo_pkg::uop_t i_disp_uop;
    logic o_disp_ack;
    ooo_pkg::wb_t [1:0] o_wb;

    logic [ooo_pkg::NUM_PREGS-1:0] wb_seen;
    ooo_pkg::preg_idx_t test_dsts [$];
    ooo_pkg::preg_idx_t next_dst;
    int errors;
    int last_fails;
    int total_got;
    int total_exp;

    ooo_issue_top #(.IQ_DEPTH(8), .ISSUE_WIDTH(2)) ooo_issue_top_inst (
        .clk(clk),
        .rst(rst),
        .i_disp_req(i_disp_req),
        .i_disp_uop(i_disp_uop),
        .o_disp_ack(o_disp_ack),
        .o_wb(o_wb)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // destinations seen on the writeback bus
    always @(posedge clk) begin
        if (rst) begin
            wb_seen <= '0;
        end else begin
            for (int l = 0; l < 2; l++) begin
                if (o_wb[l].vld) begin
                    wb_seen[o_wb[l].dst] <= 1'b1;
                end
            end
        end
    end

    function automatic int checker_fails();
        return ooo_issue_top_inst.ooo_issue_checker_inst.fail_cnt;
    endfunction

    function automatic ooo_pkg::uop_t make_uop(
        input ooo_pkg::alu_op_e op,
        input ooo_pkg::preg_idx_t s0,
        input ooo_pkg::preg_idx_t s1,
        input ooo_pkg::preg_idx_t dst,
        input ooo_pkg::xlen_t imm
    );
        ooo_pkg::uop_t u;
        u.op = op;
        u.src[0] = s0;
        u.src[1] = s1;
        u.dst = dst;
        u.imm = imm;
        return u;
    endfunction

    // fresh register per result, p0 stays zero
    function automatic ooo_pkg::preg_idx_t alloc_dst();
        ooo_pkg::preg_idx_t d;
        d = next_dst;
        next_dst++;
        test_dsts.push_back(d);
        return d;
    endfunction

    function automatic int count_arrived();
        int n;
        n = 0;
        foreach (test_dsts[i]) begin
            n += wb_seen[test_dsts[i]];
        end
        return n;
    endfunction

    // four-phase handshake, entered 2 ns after a rising edge
    task automatic dispatch_uop(input ooo_pkg::uop_t uop);
        int waited;
        i_disp_uop = uop;
        i_disp_req = 1'b1;
        waited = 0;
        while (o_disp_ack !== 1'b1 && waited < 200) begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (o_disp_ack !== 1'b1) begin
            errors++;
            $display("error: no dispatch ack for destination p%0d", uop.dst);
        end
        i_disp_req = 1'b0;
        waited = 0;
        while (o_disp_ack !== 1'b0 && waited < 200) begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (o_disp_ack !== 1'b0) begin
            errors++;
            $display("error: dispatch ack stayed high after req dropped");
        end
    endtask

    task automatic finish_test(input string name);
        int waited;
        int got;
        int fails;
        waited = 0;
        got = count_arrived();
        while (got < test_dsts.size() && waited < 100) begin
            @(posedge clk);
            #2;
            waited++;
            got = count_arrived();
        end
        fails = checker_fails() - last_fails;
        last_fails = checker_fails();
        total_got += got;
        total_exp += test_dsts.size();
        if (got < test_dsts.size()) begin
            errors++;
            $display("error: %s timed out with %0d results missing", name,
                     test_dsts.size() - got);
        end
        $display("test %s: %0d of %0d results, %0d assertion failures, %s", name, got,
                 test_dsts.size(), fails,
                 (got == test_dsts.size() && fails == 0) ? "ok" : "failed");
        test_dsts.delete();
    endtask

    initial begin : watchdog
        repeat (5000) @(posedge clk);
        $display("error: simulation did not finish in time");
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        ooo_pkg::preg_idx_t base_regs [6];
        ooo_pkg::preg_idx_t d;
        ooo_pkg::preg_idx_t prev;
        ooo_pkg::preg_idx_t src_reg;
        ooo_pkg::alu_op_e op;
        void'($urandom(85));
        errors = 0;
        last_fails = 0;
        total_got = 0;
        total_exp = 0;
        next_dst = 1;
        rst = 1'b1;
        i_disp_req = 1'b0;
        i_disp_uop = '0;
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;
        @(posedge clk);
        #2;
        finish_test("reset state");

        // LIs, then ADDIs on their results
        for (int k = 0; k < 3; k++) begin
            d = alloc_dst();
            base_regs[k] = d;
            dispatch_uop(make_uop(ooo_pkg::ALU_LI, 0, 0, d, $urandom()));
        end
        for (int k = 0; k < 3; k++) begin
            d = alloc_dst();
            base_regs[k + 3] = d;
            dispatch_uop(make_uop(ooo_pkg::ALU_ADDI, base_regs[k], 0, d, $urandom()));
        end
        finish_test("independent results");

        // each link reads the one before
        prev = alloc_dst();
        dispatch_uop(make_uop(ooo_pkg::ALU_LI, 0, 0, prev, 32'h0000_1234));
        for (int k = 0; k < 9; k++) begin
            d = alloc_dst();
            op = (k % 3 == 0) ? ooo_pkg::ALU_ADD :
                 (k % 3 == 1) ? ooo_pkg::ALU_SUB : ooo_pkg::ALU_XOR;
            dispatch_uop(make_uop(op, prev, (k == 0) ? prev : base_regs[k % 6], d, '0));
            prev = d;
        end
        finish_test("dependency chain");

        for (int k = 0; k < 16; k++) begin
            d = alloc_dst();
            op = ooo_pkg::alu_op_e'($urandom_range(4, 0));
            dispatch_uop(make_uop(op, base_regs[$urandom_range(5, 0)],
                                  base_regs[$urandom_range(5, 0)], d, $urandom()));
        end
        finish_test("dual issue");

        // consumers first, the LI of their source comes last
        src_reg = alloc_dst();
        for (int k = 0; k < 8; k++) begin
            d = alloc_dst();
            dispatch_uop(make_uop(ooo_pkg::ALU_ADDI, src_reg, 0, d, 32'(k + 1)));
        end
        dispatch_uop(make_uop(ooo_pkg::ALU_LI, 0, 0, src_reg, 32'hcafe_0001));
        finish_test("back-pressure");

        $display("summary: %0d of %0d results, %0d errors, %0d assertion failures",
                 total_got, total_exp, errors, checker_fails());
        if (errors == 0 && checker_fails() == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: ooo_issue.f
hw/ooo_pkg.sv
hw/dispatch_rx.sv
hw/ready_scoreboard.sv
hw/issue_queue.sv
hw/operand_read.sv
hw/alu_pipe.sv
hw/ooo_issue_top.sv
bench/ooo_issue_checker.sv
bench/ooo_issue_tb.sv
